/* axil_simple_slave_settings.svh */
`ifndef AXIL_SIMPLE_SLAVE_SETTINGS_SVH
`define AXIL_SIMPLE_SLAVE_SETTINGS_SVH

// Address window of the slave.
// The start address is inside the window and the end address is the first one outside it.
`define AXIL_SS_ADDR_START 32'h0000_1000
`define AXIL_SS_ADDR_END   32'h0000_2000

// Returned on every read hit and required on every write for an OKAY response.
`define AXIL_SS_DATA_WORD  32'h0000_ffff

// Cycles from request acceptance to response valid.
// Must be at least 1 and must fit the 4-bit delay counter.
`define AXIL_SS_RESP_DELAY 3

`endif

/* axil_bus_pkg.sv */
package axil_bus_pkg;

    // Byte address on the AW and AR channels.
    typedef logic [31:0] addr_t;

    // Data word on the W and R channels.
    typedef logic [31:0] data_t;

    // One strobe bit per data byte.
    typedef logic [3:0] strb_t;

    // Response codes on the B and R channels.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

endpackage

/* axil_slave_pkg.sv */
package axil_slave_pkg;

    // Write channel states.
    // AW and W can arrive in either order, so each half has its own waiting state.
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_GOT_ADDR,
        WR_GOT_DATA,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

    // Read channel states.
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    // Response delay counter.
    typedef logic [3:0] delay_t;

endpackage

/* axil_dec_if.sv */
`timescale 1ns/100ps

interface axil_dec_if;

    axil_bus_pkg::addr_t wr_addr;  // Captured AW address.
    axil_bus_pkg::data_t wr_data;  // Captured W data.
    axil_bus_pkg::resp_t wr_resp;  // Response for the captured write.

    axil_bus_pkg::addr_t rd_addr;  // Captured AR address.
    axil_bus_pkg::resp_t rd_resp;  // Response for the captured read.
    axil_bus_pkg::data_t rd_data;  // Read data for the captured read.

    modport fsm (
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  wr_resp,
        input  rd_resp,
        input  rd_data
    );

    modport dec (
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output wr_resp,
        output rd_resp,
        output rd_data
    );

endinterface

/* axil_window_decode.sv */
`timescale 1ns/100ps

`include "axil_simple_slave_settings.svh"

module axil_window_decode (
    axil_dec_if.dec dec
);

    localparam axil_bus_pkg::addr_t ADDR_START = `AXIL_SS_ADDR_START;
    localparam axil_bus_pkg::addr_t ADDR_END   = `AXIL_SS_ADDR_END;
    localparam axil_bus_pkg::data_t DATA_WORD  = `AXIL_SS_DATA_WORD;

    logic wr_hit;
    logic wr_match;
    logic rd_hit;

    assign wr_hit   = (dec.wr_addr >= ADDR_START) && (dec.wr_addr < ADDR_END);
    assign wr_match = (dec.wr_data == DATA_WORD);  // Strobes play no part in this compare.
    assign rd_hit   = (dec.rd_addr >= ADDR_START) && (dec.rd_addr < ADDR_END);

    // A write only succeeds when it hits the window with exactly the data word.
    always_comb begin
        if (wr_hit && wr_match) begin
            dec.wr_resp = axil_bus_pkg::RESP_OKAY;
        end else begin
            dec.wr_resp = axil_bus_pkg::RESP_DECERR;
        end
    end

    always_comb begin
        if (rd_hit) begin
            dec.rd_resp = axil_bus_pkg::RESP_OKAY;
            dec.rd_data = DATA_WORD;
        end else begin
            dec.rd_resp = axil_bus_pkg::RESP_DECERR;
            dec.rd_data = '0;  // Misses read back as zero.
        end
    end

endmodule

/* axil_resp_timer.sv */
`timescale 1ns/100ps

`include "axil_simple_slave_settings.svh"

module axil_resp_timer (
    input  logic seq,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam axil_slave_pkg::delay_t LOAD_VALUE =
        axil_slave_pkg::delay_t'(`AXIL_SS_RESP_DELAY);

    axil_slave_pkg::delay_t count;

    // The start edge loads the full delay and the count then runs down to zero.
    // Done is seen while the count sits at one, and the fsm registers the
    // response on the following edge. The response valid thus rises exactly
    // the configured number of edges after acceptance, even for a delay of one.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= LOAD_VALUE;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == axil_slave_pkg::delay_t'(1));  // Single-cycle pulse per start.

endmodule

/* axil_slave_fsm.sv */
`timescale 1ns/100ps

module axil_slave_fsm (
    input  logic                seq,
    input  logic                rst_n,

    input  logic                awvalid,
    output logic                awready,
    input  axil_bus_pkg::addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  axil_bus_pkg::data_t wdata,
    output logic                bvalid,
    input  logic                bready,
    output axil_bus_pkg::resp_t bresp,

    input  logic                arvalid,
    output logic                arready,
    input  axil_bus_pkg::addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output axil_bus_pkg::data_t rdata,
    output axil_bus_pkg::resp_t rresp,

    axil_dec_if.fsm             dec,

    output logic                wr_start,
    input  logic                wr_done,
    output logic                rd_start,
    input  logic                rd_done
);

    axil_slave_pkg::wr_state_t wr_state;
    axil_slave_pkg::wr_state_t wr_state_nxt;
    axil_slave_pkg::rd_state_t rd_state;
    axil_slave_pkg::rd_state_t rd_state_nxt;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;

    axil_bus_pkg::addr_t wr_addr_q;
    axil_bus_pkg::data_t wr_data_q;
    axil_bus_pkg::addr_t rd_addr_q;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;

    assign dec.wr_addr = wr_addr_q;
    assign dec.wr_data = wr_data_q;
    assign dec.rd_addr = rd_addr_q;

    // The timer starts in the cycle whose edge captures the last write beat.
    always_comb begin
        wr_state_nxt = wr_state;
        wr_start     = 1'b0;
        case (wr_state)
            axil_slave_pkg::WR_IDLE: begin
                if (aw_hs && w_hs) begin
                    wr_state_nxt = axil_slave_pkg::WR_WAIT;
                    wr_start     = 1'b1;
                end else if (aw_hs) begin
                    wr_state_nxt = axil_slave_pkg::WR_GOT_ADDR;
                end else if (w_hs) begin
                    wr_state_nxt = axil_slave_pkg::WR_GOT_DATA;
                end
            end
            axil_slave_pkg::WR_GOT_ADDR: begin
                if (w_hs) begin
                    wr_state_nxt = axil_slave_pkg::WR_WAIT;
                    wr_start     = 1'b1;
                end
            end
            axil_slave_pkg::WR_GOT_DATA: begin
                if (aw_hs) begin
                    wr_state_nxt = axil_slave_pkg::WR_WAIT;
                    wr_start     = 1'b1;
                end
            end
            axil_slave_pkg::WR_WAIT: begin
                if (wr_done) begin
                    wr_state_nxt = axil_slave_pkg::WR_RESP;
                end
            end
            axil_slave_pkg::WR_RESP: begin
                if (bready) begin
                    wr_state_nxt = axil_slave_pkg::WR_IDLE;
                end
            end
            default: begin
                wr_state_nxt = axil_slave_pkg::WR_IDLE;
            end
        endcase
    end

    always_comb begin
        rd_state_nxt = rd_state;
        rd_start     = 1'b0;
        case (rd_state)
            axil_slave_pkg::RD_IDLE: begin
                if (ar_hs) begin
                    rd_state_nxt = axil_slave_pkg::RD_WAIT;
                    rd_start     = 1'b1;
                end
            end
            axil_slave_pkg::RD_WAIT: begin
                if (rd_done) begin
                    rd_state_nxt = axil_slave_pkg::RD_RESP;
                end
            end
            axil_slave_pkg::RD_RESP: begin
                if (rready) begin
                    rd_state_nxt = axil_slave_pkg::RD_IDLE;
                end
            end
            default: begin
                rd_state_nxt = axil_slave_pkg::RD_IDLE;
            end
        endcase
    end

    // Readies and valids are registered from the next state so they line up with it.
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= axil_slave_pkg::WR_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            rd_state <= axil_slave_pkg::RD_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            wr_state <= wr_state_nxt;
            awready  <= (wr_state_nxt == axil_slave_pkg::WR_IDLE) ||
                        (wr_state_nxt == axil_slave_pkg::WR_GOT_DATA);
            wready   <= (wr_state_nxt == axil_slave_pkg::WR_IDLE) ||
                        (wr_state_nxt == axil_slave_pkg::WR_GOT_ADDR);
            bvalid   <= (wr_state_nxt == axil_slave_pkg::WR_RESP);
            rd_state <= rd_state_nxt;
            arready  <= (rd_state_nxt == axil_slave_pkg::RD_IDLE);
            rvalid   <= (rd_state_nxt == axil_slave_pkg::RD_RESP);
        end
    end

    always_ff @(posedge seq) begin
        if (aw_hs) begin
            wr_addr_q <= awaddr;
        end
        if (w_hs) begin
            wr_data_q <= wdata;
        end
        if (ar_hs) begin
            rd_addr_q <= araddr;
        end
        if ((wr_state == axil_slave_pkg::WR_WAIT) && wr_done) begin
            bresp <= dec.wr_resp;  // Held until the B handshake.
        end
        if ((rd_state == axil_slave_pkg::RD_WAIT) && rd_done) begin
            rresp <= dec.rd_resp;
            rdata <= dec.rd_data;
        end
    end

endmodule

/* axil_simple_slave.sv */
`timescale 1ns/100ps

module axil_simple_slave (
    input  logic                seq,
    input  logic                rst_n,

    input  logic                awvalid,
    output logic                awready,
    input  axil_bus_pkg::addr_t awaddr,

    input  logic                wvalid,
    output logic                wready,
    input  axil_bus_pkg::data_t wdata,
    input  axil_bus_pkg::strb_t wstrb,  // Accepted with each beat but never used, writes store nothing.

    output logic                bvalid,
    input  logic                bready,
    output axil_bus_pkg::resp_t bresp,

    input  logic                arvalid,
    output logic                arready,
    input  axil_bus_pkg::addr_t araddr,

    output logic                rvalid,
    input  logic                rready,
    output axil_bus_pkg::data_t rdata,
    output axil_bus_pkg::resp_t rresp
);

    logic wr_start;
    logic wr_done;
    logic rd_start;
    logic rd_done;

    axil_dec_if dec_if_inst ();

    axil_slave_fsm fsm_inst (
        .seq      (seq),
        .rst_n    (rst_n),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .dec      (dec_if_inst.fsm),
        .wr_start (wr_start),
        .wr_done  (wr_done),
        .rd_start (rd_start),
        .rd_done  (rd_done)
    );

    axil_window_decode decode_inst (
        .dec (dec_if_inst.dec)
    );

    axil_resp_timer wr_timer_inst (
        .seq   (seq),
        .rst_n (rst_n),
        .start (wr_start),
        .done  (wr_done)
    );

    axil_resp_timer rd_timer_inst (
        .seq   (seq),
        .rst_n (rst_n),
        .start (rd_start),
        .done  (rd_done)
    );

endmodule

/* axil_simple_slave_asserts.sv */
`timescale 1ns/100ps

module axil_simple_slave_asserts (
    input logic                seq,
    input logic                rst_n,
    input logic                awready,
    input logic                wready,
    input logic                bvalid,
    input logic                bready,
    input axil_bus_pkg::resp_t bresp,
    input logic                arready,
    input logic                rvalid,
    input logic                rready,
    input axil_bus_pkg::data_t rdata,
    input axil_bus_pkg::resp_t rresp
);

    // A write response stays up and unchanged until the master takes it.
    b_hold: assert property (@(posedge seq) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else $error("B response dropped or changed before bready.");

    r_hold: assert property (@(posedge seq) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rresp) && $stable(rdata)))
        else $error("R response dropped or changed before rready.");

    // One transaction per channel, so request readies are down while a response waits.
    b_blocks_req: assert property (@(posedge seq) disable iff (!rst_n)
        bvalid |-> (!awready && !wready))
        else $error("Write request ready while a B response is pending.");

    r_blocks_req: assert property (@(posedge seq) disable iff (!rst_n)
        rvalid |-> !arready)
        else $error("Read request ready while an R response is pending.");

    valid_in_reset: assert property (@(posedge seq)
        !rst_n |-> (!bvalid && !rvalid))
        else $error("Response valid while reset is asserted.");

endmodule

/* axil_simple_slave_tb.sv */
`timescale 1ns/100ps

`include "axil_simple_slave_settings.svh"

module axil_simple_slave_tb;

    localparam int unsigned SEED       = 32'h41ec_b52e;
    localparam int          DELAY      = `AXIL_SS_RESP_DELAY;
    localparam int          NUM_DIR_RD = 7;
    localparam int          NUM_DIR_WR = 5;
    localparam int          NUM_STALL  = 10;
    localparam int          NUM_RANDOM = 40;
    localparam int          NUM_WR     = 3 * NUM_DIR_WR + NUM_STALL + NUM_RANDOM;
    localparam int          NUM_RD     = NUM_DIR_RD + NUM_STALL + NUM_RANDOM;
    localparam int          NUM_TXN    = NUM_WR + NUM_RD;

    localparam axil_bus_pkg::addr_t DIR_RD_ADDR [NUM_DIR_RD] = '{
        32'h0000_1000, 32'h0000_1004, 32'h0000_1ffc, 32'h0000_2000,
        32'h0000_0ffc, 32'h0000_0000, 32'hffff_fffc
    };
    localparam axil_bus_pkg::addr_t DIR_WR_ADDR [NUM_DIR_WR] = '{
        32'h0000_1000, 32'h0000_1ffc, 32'h0000_1010, 32'h0000_2000, 32'h0000_0ffc
    };
    localparam axil_bus_pkg::data_t DIR_WR_DATA [NUM_DIR_WR] = '{
        32'h0000_ffff, 32'h0000_ffff, 32'h0000_fffe, 32'h0000_ffff, 32'h0000_ffff
    };

    logic                seq;
    logic                rst_n;
    logic                awvalid;
    logic                awready;
    axil_bus_pkg::addr_t awaddr;
    logic                wvalid;
    logic                wready;
    axil_bus_pkg::data_t wdata;
    axil_bus_pkg::strb_t wstrb;
    logic                bvalid;
    logic                bready;
    axil_bus_pkg::resp_t bresp;
    logic                arvalid;
    logic                arready;
    axil_bus_pkg::addr_t araddr;
    logic                rvalid;
    logic                rready;
    axil_bus_pkg::data_t rdata;
    axil_bus_pkg::resp_t rresp;

    logic stall_en;
    int   wr_issued;
    int   rd_issued;
    int   wr_taken;
    int   rd_taken;

    // Monitor state.
    int                  cyc;
    logic                aw_got;
    logic                w_got;
    logic                wr_pend;
    logic                b_seen;
    logic                rd_pend;
    logic                r_seen;
    int                  wr_acc_cyc;
    int                  rd_acc_cyc;
    axil_bus_pkg::addr_t aw_addr_m;
    axil_bus_pkg::data_t w_data_m;
    axil_bus_pkg::resp_t wr_exp_resp;
    axil_bus_pkg::data_t wr_exp_unused;
    axil_bus_pkg::resp_t rd_exp_resp;
    axil_bus_pkg::data_t rd_exp_data;
    axil_bus_pkg::resp_t b_held;
    axil_bus_pkg::resp_t r_held;
    axil_bus_pkg::data_t rdata_held;

    axil_simple_slave axil_simple_slave_inst (
        .seq     (seq),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    bind axil_slave_fsm axil_simple_slave_asserts asserts_inst (
        .seq     (seq),
        .rst_n   (rst_n),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arready (arready),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        seq = 1'b0;
        forever #5 seq = ~seq;
    end

    // Expected response from the window and data-word rule alone.
    function automatic void exp_resp(
        input  axil_bus_pkg::addr_t addr,
        input  axil_bus_pkg::data_t data,
        input  logic                is_write,
        output axil_bus_pkg::resp_t resp,
        output axil_bus_pkg::data_t rd_data
    );
        logic in_window;
        in_window = (addr >= `AXIL_SS_ADDR_START) && (addr < `AXIL_SS_ADDR_END);
        resp      = axil_bus_pkg::RESP_DECERR;
        rd_data   = '0;
        if (is_write) begin
            if (in_window && (data == `AXIL_SS_DATA_WORD)) begin
                resp = axil_bus_pkg::RESP_OKAY;
            end
        end else if (in_window) begin
            resp    = axil_bus_pkg::RESP_OKAY;
            rd_data = `AXIL_SS_DATA_WORD;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    function automatic axil_bus_pkg::addr_t pick_addr();
        int unsigned sel;
        sel = $urandom_range(3, 0);
        case (sel)
            0: return `AXIL_SS_ADDR_START +
                      $urandom_range(`AXIL_SS_ADDR_END - `AXIL_SS_ADDR_START - 1, 0);
            1: return `AXIL_SS_ADDR_START;
            2: return `AXIL_SS_ADDR_END;
            default: return axil_bus_pkg::addr_t'($urandom());
        endcase
    endfunction

    function automatic axil_bus_pkg::data_t pick_data();
        if ($urandom_range(1, 0) != 0) begin
            return `AXIL_SS_DATA_WORD;
        end
        return axil_bus_pkg::data_t'($urandom());
    endfunction

    // All drivers start and end 1 ns after a rising edge.
    task automatic aw_beat(input axil_bus_pkg::addr_t addr);
        awaddr  = addr;
        awvalid = 1'b1;
        do @(negedge seq); while (!awready);
        @(posedge seq);
        #1;
        awvalid = 1'b0;
    endtask

    task automatic w_beat(input axil_bus_pkg::data_t data, input axil_bus_pkg::strb_t strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        do @(negedge seq); while (!wready);
        @(posedge seq);
        #1;
        wvalid = 1'b0;
    endtask

    task automatic aw_w_together(input axil_bus_pkg::addr_t addr,
                                 input axil_bus_pkg::data_t data,
                                 input axil_bus_pkg::strb_t strb);
        logic aw_fire;
        logic w_fire;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            @(negedge seq);
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(posedge seq);
            #1;
            if (aw_fire) awvalid = 1'b0;
            if (w_fire) wvalid = 1'b0;
        end
    endtask

    // Order 0 sends AW first, 1 sends W first, 2 sends both at once.
    task automatic write_once(input axil_bus_pkg::addr_t addr, input axil_bus_pkg::data_t data,
                              input int order);
        axil_bus_pkg::strb_t strb;
        strb      = axil_bus_pkg::strb_t'($urandom());
        wr_issued = wr_issued + 1;
        if (order == 0) begin
            aw_beat(addr);
            w_beat(data, strb);
        end else if (order == 1) begin
            w_beat(data, strb);
            aw_beat(addr);
        end else begin
            aw_w_together(addr, data, strb);
        end
    endtask

    task automatic read_once(input axil_bus_pkg::addr_t addr);
        rd_issued = rd_issued + 1;
        araddr    = addr;
        arvalid   = 1'b1;
        do @(negedge seq); while (!arready);
        @(posedge seq);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic idle_for(input int unsigned n);
        if (n != 0) begin
            repeat (n) @(posedge seq);
            #1;
        end
    endtask

    task automatic drain();
        wait ((wr_taken == wr_issued) && (rd_taken == rd_issued));
        @(posedge seq);
        #1;
    endtask

    // Response readies, held high unless stalls are enabled.
    initial begin
        bready = 1'b0;
        rready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge seq);
            #1;
            bready = stall_en ? ($urandom_range(1, 0) != 0) : 1'b1;
            rready = stall_en ? ($urandom_range(1, 0) != 0) : 1'b1;
        end
    end

    // Samples at the falling edge, where inputs and outputs are settled.
    always @(negedge seq) begin
        if (!rst_n) begin
            check("bvalid in reset", 32'd0, 32'(bvalid));
            check("rvalid in reset", 32'd0, 32'(rvalid));
            cyc     = 0;
            aw_got  = 1'b0;
            w_got   = 1'b0;
            wr_pend = 1'b0;
            b_seen  = 1'b0;
            rd_pend = 1'b0;
            r_seen  = 1'b0;
        end else begin
            cyc = cyc + 1;
            // Readies follow the handshakes seen at earlier falling edges.
            if (cyc > 1) begin
                check("awready", 32'(!aw_got && !wr_pend), 32'(awready));
                check("wready", 32'(!w_got && !wr_pend), 32'(wready));
                check("arready", 32'(!rd_pend), 32'(arready));
            end
            if (bvalid) begin
                if (!b_seen) begin
                    check("bvalid without request", 32'd1, 32'(wr_pend));
                    check("write latency", DELAY, cyc - wr_acc_cyc);
                    check("bresp", 32'(wr_exp_resp), 32'(bresp));
                    b_seen = 1'b1;
                    b_held = bresp;
                end else begin
                    check("bresp held", 32'(b_held), 32'(bresp));
                end
                if (bready) begin
                    b_seen   = 1'b0;
                    wr_pend  = 1'b0;
                    wr_taken = wr_taken + 1;
                end
            end
            // A handshake seen here completes at the next rising edge.
            if (awvalid && awready) begin
                check("aw accepted while busy", 32'd0, 32'(aw_got || wr_pend));
                aw_got    = 1'b1;
                aw_addr_m = awaddr;
            end
            if (wvalid && wready) begin
                check("w accepted while busy", 32'd0, 32'(w_got || wr_pend));
                w_got    = 1'b1;
                w_data_m = wdata;
            end
            if (aw_got && w_got) begin
                wr_pend    = 1'b1;
                wr_acc_cyc = cyc + 1;
                aw_got     = 1'b0;
                w_got      = 1'b0;
                exp_resp(aw_addr_m, w_data_m, 1'b1, wr_exp_resp, wr_exp_unused);
            end
            if (rvalid) begin
                if (!r_seen) begin
                    check("rvalid without request", 32'd1, 32'(rd_pend));
                    check("read latency", DELAY, cyc - rd_acc_cyc);
                    check("rresp", 32'(rd_exp_resp), 32'(rresp));
                    check("rdata", rd_exp_data, rdata);
                    r_seen     = 1'b1;
                    r_held     = rresp;
                    rdata_held = rdata;
                end else begin
                    check("rresp held", 32'(r_held), 32'(rresp));
                    check("rdata held", rdata_held, rdata);
                end
                if (rready) begin
                    r_seen   = 1'b0;
                    rd_pend  = 1'b0;
                    rd_taken = rd_taken + 1;
                end
            end
            if (arvalid && arready) begin
                check("ar accepted while busy", 32'd0, 32'(rd_pend));
                rd_pend    = 1'b1;
                rd_acc_cyc = cyc + 1;
                exp_resp(araddr, '0, 1'b0, rd_exp_resp, rd_exp_data);
            end
        end
    end

    initial begin
        repeat (40 * NUM_TXN) @(posedge seq);
        $display("Watchdog expired: the DUT stopped answering requests.");
        $display("TESTS FAILED");
        $fatal(1, "Timeout.");
    end

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        stall_en  = 1'b0;
        wr_issued = 0;
        rd_issued = 0;
        wr_taken  = 0;
        rd_taken  = 0;
        repeat (4) @(posedge seq);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < NUM_DIR_RD; i++) begin
            read_once(DIR_RD_ADDR[i]);
        end
        drain();

        for (int i = 0; i < NUM_DIR_WR; i++) begin
            for (int order = 0; order < 3; order++) begin
                write_once(DIR_WR_ADDR[i], DIR_WR_DATA[i], order);
            end
        end
        drain();

        stall_en = 1'b1;  // Random back-pressure on B and R from here on.
        fork
            for (int n = 0; n < NUM_STALL; n++) begin
                write_once(pick_addr(), pick_data(), int'($urandom_range(2, 0)));
            end
            for (int n = 0; n < NUM_STALL; n++) begin
                read_once(pick_addr());
            end
        join
        drain();

        fork
            for (int n = 0; n < NUM_RANDOM; n++) begin
                idle_for($urandom_range(3, 0));
                write_once(pick_addr(), pick_data(), int'($urandom_range(2, 0)));
            end
            for (int n = 0; n < NUM_RANDOM; n++) begin
                idle_for($urandom_range(3, 0));
                read_once(pick_addr());
            end
        join
        drain();

        if ((wr_taken == NUM_WR) && (rd_taken == NUM_RD)) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Transaction count mismatch: %0d writes and %0d reads completed.",
                     wr_taken, rd_taken);
            $display("TESTS FAILED");
            $fatal(1, "Incomplete run.");
        end
    end

endmodule

/* axil_simple_slave.f */
+incdir+.
axil_bus_pkg.sv
axil_slave_pkg.sv
axil_dec_if.sv
axil_window_decode.sv
axil_resp_timer.sv
axil_slave_fsm.sv
axil_simple_slave.sv
axil_simple_slave_asserts.sv
axil_simple_slave_tb.sv

/* Makefile */
# Verilator build and run for the AXI4-Lite simple slave.

VERILATOR ?= verilator
TOP       ?= axil_simple_slave_tb
FILELIST  ?= axil_simple_slave.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) axil_simple_slave_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message.
run: compile
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
